// File: build.f
+incdir+include
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_top.sv
testbench/uart_tb.sv

// File: Bender.yml
package:
  name: uart

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/uart_pkg.sv
      - design/uart_tx.sv
      - design/uart_rx.sv
      - design/uart_regs.sv
      - design/uart_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/uart_tb.sv

// File: testbench/uart_tb.sv
`include "uart_config.svh"

module uart_tb;
  import uart_pkg::*;

  localparam int TX_FRAMES = 8;
  // twelve divisors per frame in each test, plus slack for bus traffic.
  localparam int CYCLE_LIMIT = 12 * 16 * TX_FRAMES + 12 * 8 + 12 * 8 + 12 * 8 * 3 + 2000;

  logic        clk;
  logic        rst_n;
  logic        rx;
  logic        select;
  logic        write;
  uart_addr_e  address;
  logic [3:0]  be;
  logic [31:0] data_in;
  logic        tx;
  logic [31:0] data_out;

  int cur_div;
  int cycles;
  int checks;
  int errors;
  int errors_base;
  int tests_run;
  int tests_failed;
  int frames_sent;
  int frames_checked;

  // receive side of the model.
  logic [7:0] m_rx_byte;
  logic       m_rx_valid;
  logic       m_overrun;
  logic       m_frame_err;

  logic [7:0] exp_tx_q[$];
  logic [9:0] mon_frame_q[$];
  logic       mon_timing_q[$];

  uart_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .select   (select),
    .write    (write),
    .address  (address),
    .be       (be),
    .data_in  (data_in),
    .tx       (tx),
    .data_out (data_out)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not end within %0d clock cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // line sequence from start bit (index 0) to stop bit (index 9).
  function automatic logic [9:0] exp_frame(input logic [7:0] b);
    return {1'b1, b, 1'b0};
  endfunction

  function automatic uart_status_t exp_status(input logic tx_ready, input logic tx_pending);
    uart_status_t s;
    s            = '0;
    s.frame_err  = m_frame_err;
    s.overrun    = m_overrun;
    s.rx_valid   = m_rx_valid;
    s.tx_pending = tx_pending;
    s.tx_ready   = tx_ready;
    s.rx_byte    = m_rx_byte;
    return s;
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at time %0t: %s expected 0x%08h, actual 0x%08h", $time, name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input uart_status_t exp,
                              input uart_status_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at time %0t: %s expected 0x%08h, actual 0x%08h", $time, name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at time %0t: %s expected 0x%02h, actual 0x%02h", $time, name, exp, act);
    end
  endtask

  task automatic check_frame(input string name, input logic [9:0] exp, input logic [9:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at time %0t: %s expected 0x%03h, actual 0x%03h", $time, name, exp, act);
    end
  endtask

  task automatic bus_write(input uart_addr_e addr, input logic [3:0] bytes,
                           input logic [31:0] word);
    @(negedge clk);
    select  = 1'b1;
    write   = 1'b1;
    address = addr;
    be      = bytes;
    data_in = word;
    @(negedge clk);
    select  = 1'b0;
    write   = 1'b0;
    be      = 4'h0;
    data_in = '0;
  endtask

  task automatic bus_read(input uart_addr_e addr, output logic [31:0] word);
    @(negedge clk);
    select  = 1'b1;
    write   = 1'b0;
    address = addr;
    @(negedge clk);
    word   = data_out;
    select = 1'b0;
  endtask

  // the bus goes idle after every read, so a taken byte is released at once.
  task automatic verify_status(input logic tx_ready, input logic tx_pending);
    uart_status_t exp;
    logic [31:0]  v;
    exp = exp_status(tx_ready, tx_pending);
    bus_read(UART_DATA, v);
    check_status("status", exp, uart_status_t'(v));
    if (m_rx_valid) begin
      m_rx_valid  = 1'b0;
      m_overrun   = 1'b0;
      m_frame_err = 1'b0;
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    uart_status_t s;
    uart_wdata_u  w;
    logic [31:0]  v;
    s = '0;
    while (!s.tx_ready) begin
      bus_read(UART_DATA, v);
      s = uart_status_t'(v);
    end
    w = '0;
    w.tx_view.tx_byte = b;
    bus_write(UART_DATA, 4'b0001, w);
    exp_tx_q.push_back(b);
    frames_sent++;
  endtask

  task automatic wait_frames();
    while (frames_checked < frames_sent) begin
      @(negedge clk);
    end
  endtask

  // one frame on rx followed by one idle bit.
  task automatic drive_frame(input logic [7:0] b, input logic stop_bit);
    logic [9:0] f;
    f    = exp_frame(b);
    f[9] = stop_bit;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      rx = f[i];
      repeat (cur_div - 1) @(negedge clk);
    end
    @(negedge clk);
    rx = 1'b1;
    repeat (cur_div - 1) @(negedge clk);
  endtask

  task automatic note_rx(input logic [7:0] b, input logic stop_ok);
    m_overrun   = m_overrun || m_rx_valid;
    m_rx_byte   = b;
    m_rx_valid  = 1'b1;
    m_frame_err = m_frame_err || !stop_ok;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors > errors_base) begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_base);
    end else begin
      $display("test %s: ok", name);
    end
    errors_base = errors;
  endtask

  // samples tx on every falling edge of the frame.
  initial begin : tx_monitor
    logic [9:0] bits;
    logic       timing_ok;
    int         div_now;
    forever begin
      @(negedge clk);
      if (rst_n && tx === 1'b0) begin
        div_now   = cur_div;
        timing_ok = 1'b1;
        bits      = '0;
        for (int i = 0; i < 10; i++) begin
          for (int c = 0; c < div_now; c++) begin
            if (i != 0 || c != 0) begin
              @(negedge clk);
            end
            if (c == 0) begin
              bits[i] = tx;
            end else if (tx !== bits[i]) begin
              timing_ok = 1'b0;
            end
          end
        end
        mon_frame_q.push_back(bits);
        mon_timing_q.push_back(timing_ok);
      end
    end
  end

  initial begin : frame_compare
    logic [9:0] f;
    logic       timing_ok;
    logic [7:0] b;
    forever begin
      @(negedge clk);
      while (mon_frame_q.size() > 0) begin
        f         = mon_frame_q.pop_front();
        timing_ok = mon_timing_q.pop_front();
        if (exp_tx_q.size() == 0) begin
          errors++;
          $display("tx sent frame 0x%03h at time %0t without an accepted write", f, $time);
        end else begin
          b = exp_tx_q.pop_front();
          check_frame("tx frame", exp_frame(b), f);
          check_byte("tx byte", b, f[8:1]);
        end
        if (!timing_ok) begin
          errors++;
          $display("a bit on tx did not last %0d cycles, frame ending at time %0t",
                   cur_div, $time);
        end
        frames_checked++;
      end
    end
  end

  initial begin : main
    uart_wdata_u w;
    logic [31:0] v;
    logic [7:0]  b;
    int          seed;
    clk            = 1'b0;
    rst_n          = 1'b0;
    rx             = 1'b1;
    select         = 1'b0;
    write          = 1'b0;
    address        = UART_DATA;
    be             = 4'h0;
    data_in        = '0;
    cur_div        = `UART_DEFAULT_DIV;
    cycles         = 0;
    checks         = 0;
    errors         = 0;
    errors_base    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    frames_sent    = 0;
    frames_checked = 0;
    m_rx_byte      = '0;
    m_rx_valid     = 1'b0;
    m_overrun      = 1'b0;
    m_frame_err    = 1'b0;
    seed           = 32'h8ca71814;
    v              = $urandom(seed);
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    bus_read(UART_DATA, v);
    check_word("status", 32'h0000_0100, v);
    bus_read(UART_ID, v);
    check_word("id", `UART_ID, v);
    bus_read(UART_DIV, v);
    check_word("div", {16'h0000, `UART_DEFAULT_DIV}, v);
    bus_read(uart_addr_e'(2'd3), v);
    check_word("address 3", 32'h0, v);
    finish_test("reset and identity");

    for (int i = 0; i < TX_FRAMES; i++) begin
      v = $urandom;
      send_byte(v[7:0]);
      // the frame is running now, so this write has to be dropped.
      w = '0;
      w.tx_view.tx_byte = v[7:0] ^ 8'h5a;
      bus_write(UART_DATA, 4'b0001, w);
      verify_status(1'b0, 1'b0);
    end
    wait_frames();
    finish_test("transmit");

    w = '0;
    w.div_view.div = 16'd8;
    bus_write(UART_DIV, 4'b0011, w);
    cur_div = 8;
    bus_read(UART_DIV, v);
    check_word("div", 32'd8, v);
    w.div_view.div = 16'd2;
    bus_write(UART_DIV, 4'b0011, w);
    bus_read(UART_DIV, v);
    check_word("div", 32'd8, v);
    v = $urandom;
    send_byte(v[7:0]);
    wait_frames();
    finish_test("divisor");

    v = $urandom;
    b = v[7:0];
    fork
      drive_frame(b, 1'b1);
      begin
        // before the stop bit is sampled, nothing has arrived yet.
        repeat (9 * cur_div) @(negedge clk);
        verify_status(1'b1, 1'b0);
      end
    join
    note_rx(b, 1'b1);
    verify_status(1'b1, 1'b0);
    verify_status(1'b1, 1'b0);
    finish_test("receive");

    v = $urandom;
    drive_frame(v[7:0], 1'b1);
    note_rx(v[7:0], 1'b1);
    v = $urandom;
    drive_frame(v[7:0], 1'b1);
    note_rx(v[7:0], 1'b1);
    verify_status(1'b1, 1'b0);
    verify_status(1'b1, 1'b0);
    v = $urandom;
    drive_frame(v[7:0], 1'b0);
    note_rx(v[7:0], 1'b0);
    verify_status(1'b1, 1'b0);
    verify_status(1'b1, 1'b0);
    finish_test("errors");

    $display("tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: design/uart_top.sv
module uart_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  input  logic                 select,
  input  logic                 write,
  input  uart_pkg::uart_addr_e address,
  input  logic [3:0]           be,
  input  logic [31:0]          data_in,
  output logic                 tx,
  output logic [31:0]          data_out
);
  import uart_pkg::*;

  logic       tx_start;
  logic       tx_ready;
  logic [7:0] tx_byte;
  logic       rx_done;
  logic [7:0] rx_data;
  logic       rx_stop_ok;
  uart_div_t  div;

  uart_regs regs_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .select     (select),
    .write      (write),
    .address    (address),
    .be         (be),
    .data_in    (data_in),
    .tx_ready   (tx_ready),
    .rx_done    (rx_done),
    .rx_data    (rx_data),
    .rx_stop_ok (rx_stop_ok),
    .data_out   (data_out),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .div        (div)
  );

  uart_tx tx_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (tx_start),
    .data       (tx_byte),
    .div        (div),
    .ready      (tx_ready),
    .serial_out (tx)
  );

  uart_rx rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .serial_in (rx),
    .div       (div),
    .done      (rx_done),
    .data      (rx_data),
    .stop_ok   (rx_stop_ok)
  );

endmodule

// File: design/uart_regs.sv
`include "uart_config.svh"

module uart_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 select,
  input  logic                 write,
  input  uart_pkg::uart_addr_e address,
  input  logic [3:0]           be,
  input  logic [31:0]          data_in,
  input  logic                 tx_ready,
  input  logic                 rx_done,
  input  logic [7:0]           rx_data,
  input  logic                 rx_stop_ok,
  output logic [31:0]          data_out,
  output logic                 tx_start,
  output logic [7:0]           tx_byte,
  output uart_pkg::uart_div_t  div
);
  import uart_pkg::*;

  uart_wdata_u  wdata;
  uart_status_t status;

  logic       host_wr;
  logic       host_rd;
  logic       host_idle;
  logic       tx_wr;
  logic       div_wr;
  logic       tx_pending;
  logic [7:0] rx_byte;
  logic       rx_valid;
  logic       rx_taken;
  logic       overrun;
  logic       frame_err;

  assign wdata     = data_in;
  assign host_wr   = select && write;
  assign host_rd   = select && !write;
  assign host_idle = !select && !write;

  // a transmit write is dropped while the transmitter is busy.
  assign tx_wr  = host_wr && (address == UART_DATA) && be[0] && tx_ready;
  assign div_wr = host_wr && (address == UART_DIV) && (be[1:0] == 2'b11) &&
                  (wdata.div_view.div >= `UART_MIN_DIV);

  assign tx_start = tx_pending && tx_ready;

  always_ff @(posedge clk) begin
    if (tx_wr) begin
      tx_byte <= wdata.tx_view.tx_byte;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_pending <= 1'b0;
      div        <= `UART_DEFAULT_DIV;
    end else begin
      if (tx_wr) begin
        tx_pending <= 1'b1;
      end else if (tx_start) begin
        tx_pending <= 1'b0;
      end
      if (div_wr) begin
        div <= wdata.div_view.div;
      end
    end
  end

  // a status read marks the byte taken, the next idle cycle releases it.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_byte   <= '0;
      rx_valid  <= 1'b0;
      rx_taken  <= 1'b0;
      overrun   <= 1'b0;
      frame_err <= 1'b0;
    end else if (rx_done) begin
      rx_byte   <= rx_data;
      rx_valid  <= 1'b1;
      rx_taken  <= 1'b0;
      overrun   <= overrun || (rx_valid && !rx_taken);
      frame_err <= frame_err || !rx_stop_ok;
    end else if (host_rd && (address == UART_DATA) && rx_valid) begin
      rx_taken <= 1'b1;
    end else if (host_idle && rx_taken) begin
      rx_valid  <= 1'b0;
      rx_taken  <= 1'b0;
      overrun   <= 1'b0;
      frame_err <= 1'b0;
    end
  end

  always_comb begin
    status            = '0;
    status.frame_err  = frame_err;
    status.overrun    = overrun;
    status.rx_valid   = rx_valid;
    status.tx_pending = tx_pending;
    status.tx_ready   = tx_ready;
    status.rx_byte    = rx_byte;
  end

  always_comb begin
    data_out = '0;
    if (host_rd) begin
      case (address)
        UART_DATA: data_out = status;
        UART_DIV:  data_out = {16'h0000, div};
        UART_ID:   data_out = `UART_ID;
        default:   data_out = '0;
      endcase
    end
  end

  // both serial engines count on a divisor large enough for mid-bit sampling.
  div_above_min: assert property (
    @(posedge clk) disable iff (!rst_n) div >= `UART_MIN_DIV
  ) else $error("uart_regs: divisor %0d below minimum", div);

endmodule

// File: design/uart_rx.sv
module uart_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                serial_in,
  input  uart_pkg::uart_div_t div,
  output logic                done,
  output logic [7:0]          data,
  output logic                stop_ok
);
  import uart_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e  state;
  logic       sync_1;
  logic       sync_2;
  logic       line_prev;
  logic       fall;
  uart_div_t  div_q;
  uart_div_t  half_div;
  uart_div_t  cyc_cnt;
  logic [2:0] bit_cnt;
  logic       bit_end;

  assign fall     = line_prev && !sync_2;
  assign half_div = div_q >> 1;
  assign bit_end  = (cyc_cnt == div_q - 16'd1);

  // two flops against metastability and a third for the edge.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_1    <= 1'b1;
      sync_2    <= 1'b1;
      line_prev <= 1'b1;
    end else begin
      sync_1    <= serial_in;
      sync_2    <= sync_1;
      line_prev <= sync_2;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= RX_IDLE;
      div_q   <= '0;
      cyc_cnt <= '0;
      bit_cnt <= '0;
      data    <= '0;
      done    <= 1'b0;
      stop_ok <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (fall) begin
            state   <= RX_START;
            div_q   <= div;
            cyc_cnt <= '0;
          end
        end
        RX_START: begin
          // middle of the start bit; a high line here was a glitch.
          if (cyc_cnt == half_div) begin
            cyc_cnt <= '0;
            bit_cnt <= '0;
            state   <= sync_2 ? RX_IDLE : RX_DATA;
          end else begin
            cyc_cnt <= cyc_cnt + 16'd1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cyc_cnt <= '0;
            data    <= {sync_2, data[7:1]};
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            cyc_cnt <= cyc_cnt + 16'd1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            done    <= 1'b1;
            stop_ok <= sync_2;
            state   <= RX_IDLE;
          end else begin
            cyc_cnt <= cyc_cnt + 16'd1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // a frame is at least ten bits long, so done cannot repeat at once.
  done_single_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) done |=> !done
  ) else $error("uart_rx: done held for two cycles");

endmodule

// File: design/uart_tx.sv
module uart_tx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic [7:0]          data,
  input  uart_pkg::uart_div_t div,
  output logic                ready,
  output logic                serial_out
);
  import uart_pkg::*;

  logic       busy;
  uart_div_t  div_q;
  uart_div_t  cyc_cnt;
  logic [3:0] bit_cnt;
  logic [8:0] shift_q;
  logic       bit_end;

  // last cycle of the bit currently on the line.
  assign bit_end = (cyc_cnt == div_q - 16'd1);

  assign ready = !busy;

  // bit_cnt 0 is the start bit, 1 to 8 the data bits, 9 the stop bit.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      serial_out <= 1'b1;
      div_q      <= '0;
      cyc_cnt    <= '0;
      bit_cnt    <= '0;
      shift_q    <= '1;
    end else if (!busy) begin
      if (start) begin
        // the start bit goes out right away.
        busy       <= 1'b1;
        serial_out <= 1'b0;
        shift_q    <= {1'b1, data};
        div_q      <= div;
        cyc_cnt    <= '0;
        bit_cnt    <= '0;
      end
    end else if (bit_end) begin
      cyc_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;
      end else begin
        serial_out <= shift_q[0];
        shift_q    <= {1'b1, shift_q[8:1]};
        bit_cnt    <= bit_cnt + 4'd1;
      end
    end else begin
      cyc_cnt <= cyc_cnt + 16'd1;
    end
  end

  // the register block must wait for ready before it starts a frame.
  start_needs_ready: assert property (
    @(posedge clk) disable iff (!rst_n) start |-> ready
  ) else $error("uart_tx: start while busy");

endmodule

// File: design/uart_pkg.sv
package uart_pkg;

  // host register map with address 3 unused and reading zero.
  typedef enum logic [1:0] {
    UART_DATA = 2'd0,
    UART_DIV  = 2'd1,
    UART_ID   = 2'd2
  } uart_addr_e;

  // clock cycles per bit.
  typedef logic [15:0] uart_div_t;

  // status word returned on a read of UART_DATA.
  typedef struct packed {
    logic [18:0] reserved;
    logic        frame_err;
    logic        overrun;
    logic        rx_valid;
    logic        tx_pending;
    logic        tx_ready;
    logic [7:0]  rx_byte;
  } uart_status_t;

  typedef struct packed {
    logic [23:0] unused;
    logic [7:0]  tx_byte;
  } uart_wdata_tx_t;

  typedef struct packed {
    logic [15:0] unused;
    uart_div_t   div;
  } uart_wdata_div_t;

  // the host write word, decoded by address.
  typedef union packed {
    uart_wdata_tx_t  tx_view;
    uart_wdata_div_t div_view;
  } uart_wdata_u;

endpackage

// File: include/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// clock cycles per serial bit after reset.
`define UART_DEFAULT_DIV 16'd16

// divisor writes below this value are dropped.
`define UART_MIN_DIV 16'd4

// constant word returned at the id address.
`define UART_ID 32'hbeef0023

`endif
